// File: logic/a_domain_pkg.sv
// every width is fixed by the 32-bit command format and the 66-bit ASIC data word, so none is tunable
package a_domain_pkg;

    // command word layout, opcode in the low bits and payload above it
    localparam int cmd_w     = 32;
    localparam int opcode_w  = 15;
    localparam int payload_w = cmd_w - opcode_w;

    localparam int stream_w  = 66;
    localparam int burst_len = 7;

    // configuration load is nine scalar words then two cut tables
    localparam int cut_count    = 15;
    localparam int scalar_words = 9;
    localparam int config_words = scalar_words + 2 * cut_count;

    typedef logic [cmd_w-1:0]     cmd_word_t;
    typedef logic [opcode_w-1:0]  opcode_t;
    typedef logic [payload_w-1:0] payload_t;
    typedef logic [stream_w-1:0]  stream_word_t;
    typedef logic [payload_w-1:0] gap_t;
    typedef logic signed [16:0]   cut1_t;
    typedef logic signed [15:0]   cut2_t;

    localparam opcode_t op_config       = 15'd1;
    localparam opcode_t op_config_ack   = 15'd2;
    localparam opcode_t op_status       = 15'd7;
    localparam opcode_t op_start        = 15'd8;
    localparam opcode_t op_ready_notice = 15'd9;
    localparam opcode_t op_stream_gap   = 15'd10;

    // fields in load order, first word loaded is the top field
    typedef struct packed {
        // 0 training, 1 training and inference sweep, 2 inference
        logic [1:0]            asic_mode;
        logic [15:0]           training_epochs;
        logic [15:0]           inference_epochs;
        logic [1:0]            dataset;
        logic [15:0]           timesteps;
        logic [15:0]           input_size_layer1;
        logic                  long_stream_mode;
        logic                  binary_classifier_mode;
        logic                  loser_encourage_mode;
        cut1_t [cut_count-1:0] layer1_cut;
        cut2_t [cut_count-1:0] layer2_cut;
    } asic_config_t;

    typedef struct packed {
        logic         valid;
        stream_word_t word;
    } stream_beat_t;

endpackage

// File: logic/asic_io_sync.sv
// start_ready passes one flop only, so the ASIC must hold it steady well beyond a clock period
module asic_io_sync (
    input  logic                       clk_a_domain,
    input  logic                       reset_n,
    input  a_domain_pkg::stream_beat_t beat_i,
    input  logic                       start_ready_raw_i,
    output a_domain_pkg::stream_beat_t asic_stream_o,
    output logic                       start_ready_o,
    output logic                       start_ready_rise_o
);

    logic                       stream_valid_q;
    a_domain_pkg::stream_word_t stream_word_q;
    logic                       start_ready_q;
    logic                       start_ready_prev_q;

    // outbound stage, valid is cleared on reset
    always_ff @(posedge clk_a_domain) begin
        if (!reset_n) begin
            stream_valid_q <= 1'b0;
        end else begin
            stream_valid_q <= beat_i.valid;
        end
    end

    always_ff @(posedge clk_a_domain) begin
        stream_word_q <= beat_i.word;
    end

    assign asic_stream_o = '{valid: stream_valid_q, word: stream_word_q};

    // inbound stage and the edge register behind it
    always_ff @(posedge clk_a_domain) begin
        if (!reset_n) begin
            start_ready_q      <= 1'b0;
            start_ready_prev_q <= 1'b0;
        end else begin
            start_ready_q      <= start_ready_raw_i;
            start_ready_prev_q <= start_ready_q;
        end
    end

    assign start_ready_o = start_ready_q;

    // high for the one cycle after the synced level goes up
    assign start_ready_rise_o = start_ready_q && !start_ready_prev_q;

endmodule

// File: logic/config_loader.sv
// loads 39 payloads in fixed order, extra loads while full are not taken, ack keeps the stored values
module config_loader (
    input  logic                       clk_a_domain,
    input  logic                       reset_n,
    input  logic                       load_i,
    input  a_domain_pkg::payload_t     payload_i,
    input  logic                       ack_i,
    output logic                       full_o,
    output a_domain_pkg::asic_config_t config_o
);

    logic [5:0]                 word_cnt_q;
    logic [3:0]                 cut_slot;
    a_domain_pkg::asic_config_t config_q;

    assign full_o = (word_cnt_q == 6'(a_domain_pkg::config_words));

    // slot inside whichever cut table the counter is in
    always_comb begin
        if (word_cnt_q < 6'(a_domain_pkg::scalar_words + a_domain_pkg::cut_count)) begin
            cut_slot = 4'(word_cnt_q - 6'(a_domain_pkg::scalar_words));
        end else begin
            cut_slot = 4'(word_cnt_q - 6'(a_domain_pkg::scalar_words + a_domain_pkg::cut_count));
        end
    end

    always_ff @(posedge clk_a_domain) begin
        if (!reset_n) begin
            word_cnt_q <= '0;
            config_q   <= '0;
        end else if (ack_i) begin
            word_cnt_q <= '0;
        end else if (load_i && !full_o) begin
            word_cnt_q <= word_cnt_q + 6'd1;
            // narrow fields keep the low payload bits
            case (word_cnt_q)
                6'd0: config_q.asic_mode              <= payload_i[1:0];
                6'd1: config_q.training_epochs        <= payload_i[15:0];
                6'd2: config_q.inference_epochs       <= payload_i[15:0];
                6'd3: config_q.dataset                <= payload_i[1:0];
                6'd4: config_q.timesteps              <= payload_i[15:0];
                6'd5: config_q.input_size_layer1      <= payload_i[15:0];
                6'd6: config_q.long_stream_mode       <= payload_i[0];
                6'd7: config_q.binary_classifier_mode <= payload_i[0];
                6'd8: config_q.loser_encourage_mode   <= payload_i[0];
                default: begin
                    if (word_cnt_q < 6'(a_domain_pkg::scalar_words + a_domain_pkg::cut_count)) begin
                        config_q.layer1_cut[cut_slot] <= a_domain_pkg::cut1_t'(payload_i);
                    end else begin
                        config_q.layer2_cut[cut_slot] <= a_domain_pkg::cut2_t'(payload_i[15:0]);
                    end
                end
            endcase
        end
    end

    assign config_o = config_q;

endmodule

// File: logic/command_decoder.sv
// one response per cycle at most, notice before ack before the head command, unknown opcodes block the FIFO
module command_decoder (
    input  logic                    clk_a_domain,
    input  logic                    reset_n,
    input  logic                    cmd_valid_i,
    input  a_domain_pkg::cmd_word_t cmd_dout_i,
    output logic                    cmd_rd_en_o,
    input  logic                    rsp_full_i,
    output logic                    rsp_wr_en_o,
    output a_domain_pkg::cmd_word_t rsp_din_o,
    input  logic                    start_ready_i,
    input  logic                    start_ready_rise_i,
    input  logic                    loader_full_i,
    output logic                    load_o,
    output a_domain_pkg::payload_t  payload_o,
    output logic                    ack_o,
    output logic                    gap_load_o,
    output a_domain_pkg::gap_t      gap_o
);

    a_domain_pkg::opcode_t  head_op;
    a_domain_pkg::payload_t head_payload;
    logic                   notice_armed_q;
    logic                   notice_fire;
    logic                   ack_fire;
    logic                   slot_free;
    logic                   cfg_pop;
    logic                   status_pop;
    logic                   start_pop;
    logic                   gap_pop;

    assign head_op      = cmd_dout_i[a_domain_pkg::opcode_w-1:0];
    assign head_payload = cmd_dout_i[a_domain_pkg::cmd_w-1:a_domain_pkg::opcode_w];

    // response slot arbitration
    assign notice_fire = notice_armed_q && start_ready_rise_i && !rsp_full_i;
    assign ack_fire    = loader_full_i && !rsp_full_i && !notice_fire;
    assign slot_free   = !rsp_full_i && !notice_fire && !ack_fire;

    // config words need no slot, only room in the loader
    assign cfg_pop    = cmd_valid_i && (head_op == a_domain_pkg::op_config) && !loader_full_i;
    assign status_pop = cmd_valid_i && (head_op == a_domain_pkg::op_status) && slot_free;
    assign start_pop  = cmd_valid_i && (head_op == a_domain_pkg::op_start) && slot_free
                        && start_ready_i;
    assign gap_pop    = cmd_valid_i && (head_op == a_domain_pkg::op_stream_gap) && slot_free;

    assign cmd_rd_en_o = cfg_pop || status_pop || start_pop || gap_pop;
    assign rsp_wr_en_o = notice_fire || ack_fire || status_pop || start_pop || gap_pop;

    always_comb begin
        rsp_din_o = '0;
        if (notice_fire) begin
            rsp_din_o = {{(a_domain_pkg::payload_w-1){1'b0}}, 1'b1,
                         a_domain_pkg::op_ready_notice};
        end else if (ack_fire) begin
            rsp_din_o = {{a_domain_pkg::payload_w{1'b0}}, a_domain_pkg::op_config_ack};
        end else if (status_pop) begin
            // bit 15 reports the synced start_ready level
            rsp_din_o = {{(a_domain_pkg::payload_w-1){1'b0}}, start_ready_i,
                         a_domain_pkg::op_status};
        end else if (start_pop) begin
            rsp_din_o = {{a_domain_pkg::payload_w{1'b0}}, a_domain_pkg::op_start};
        end else if (gap_pop) begin
            rsp_din_o = cmd_dout_i;
        end
    end

    // armed by an accepted start, cleared once the notice is written
    always_ff @(posedge clk_a_domain) begin
        if (!reset_n) begin
            notice_armed_q <= 1'b0;
        end else if (start_pop) begin
            notice_armed_q <= 1'b1;
        end else if (notice_fire) begin
            notice_armed_q <= 1'b0;
        end
    end

    assign load_o     = cfg_pop;
    assign payload_o  = head_payload;
    assign ack_o      = ack_fire;
    assign gap_load_o = gap_pop;
    assign gap_o      = a_domain_pkg::gap_t'(head_payload);

endmodule

// File: logic/stream_burst_gate.sv
// a zero gap stops the stream, a new gap only applies from the next pause on
module stream_burst_gate (
    input  logic                       clk_a_domain,
    input  logic                       reset_n,
    input  logic                       gap_load_i,
    input  a_domain_pkg::gap_t         gap_i,
    input  logic                       data_valid_i,
    input  a_domain_pkg::stream_word_t data_dout_i,
    output logic                       data_rd_en_o,
    output a_domain_pkg::stream_beat_t beat_o
);

    typedef enum logic {
        gate_burst,
        gate_pause
    } gate_state_t;

    gate_state_t        state_q;
    a_domain_pkg::gap_t gap_q;
    a_domain_pkg::gap_t pause_cnt_q;
    logic [2:0]         burst_cnt_q;
    logic               last_pop;

    assign data_rd_en_o = data_valid_i && (state_q == gate_burst) && (gap_q != '0);
    assign last_pop     = data_rd_en_o && (burst_cnt_q == 3'(a_domain_pkg::burst_len - 1));

    assign beat_o = '{valid: data_rd_en_o, word: data_rd_en_o ? data_dout_i : '0};

    always_ff @(posedge clk_a_domain) begin
        if (!reset_n) begin
            state_q     <= gate_burst;
            gap_q       <= '0;
            pause_cnt_q <= '0;
            burst_cnt_q <= '0;
        end else begin
            if (gap_load_i) begin
                gap_q <= gap_i;
            end
            case (state_q)
                gate_burst: begin
                    // pause length is latched here so a mid-pause change waits
                    if (last_pop) begin
                        state_q     <= gate_pause;
                        burst_cnt_q <= '0;
                        pause_cnt_q <= gap_q;
                    end else if (data_rd_en_o) begin
                        burst_cnt_q <= burst_cnt_q + 3'd1;
                    end
                end
                gate_pause: begin
                    if (pause_cnt_q <= a_domain_pkg::gap_t'(1)) begin
                        state_q     <= gate_burst;
                        pause_cnt_q <= '0;
                    end else begin
                        pause_cnt_q <= pause_cnt_q - a_domain_pkg::gap_t'(1);
                    end
                end
                default: state_q <= gate_burst;
            endcase
        end
    end

endmodule

// File: logic/a_domain_top.sv
// FIFO strobes are combinational, so FIFOs must present a word with valid and take rd_en the same cycle
module a_domain_top (
    input  logic                       clk_a_domain,
    input  logic                       reset_n,
    // command FIFO
    input  logic                       cmd_valid_i,
    input  a_domain_pkg::cmd_word_t    cmd_dout_i,
    output logic                       cmd_rd_en_o,
    // data FIFO
    input  logic                       data_valid_i,
    input  a_domain_pkg::stream_word_t data_dout_i,
    output logic                       data_rd_en_o,
    // response FIFO
    input  logic                       rsp_full_i,
    output logic                       rsp_wr_en_o,
    output a_domain_pkg::cmd_word_t    rsp_din_o,
    // ASIC side
    input  logic                       asic_start_ready_i,
    output logic                       asic_reset_n_o,
    output a_domain_pkg::stream_beat_t asic_stream_o,
    output a_domain_pkg::asic_config_t asic_config_o
);

    a_domain_pkg::stream_beat_t gate_beat;
    a_domain_pkg::payload_t     load_payload;
    a_domain_pkg::gap_t         gap_value;
    logic                       start_ready;
    logic                       start_ready_rise;
    logic                       loader_full;
    logic                       load;
    logic                       ack;
    logic                       gap_load;

    // the ASIC resets together with this domain
    assign asic_reset_n_o = reset_n;

    asic_io_sync u_io_sync (
        .clk_a_domain       (clk_a_domain),
        .reset_n            (reset_n),
        .beat_i             (gate_beat),
        .start_ready_raw_i  (asic_start_ready_i),
        .asic_stream_o      (asic_stream_o),
        .start_ready_o      (start_ready),
        .start_ready_rise_o (start_ready_rise)
    );

    config_loader u_config_loader (
        .clk_a_domain (clk_a_domain),
        .reset_n      (reset_n),
        .load_i       (load),
        .payload_i    (load_payload),
        .ack_i        (ack),
        .full_o       (loader_full),
        .config_o     (asic_config_o)
    );

    command_decoder u_command_decoder (
        .clk_a_domain       (clk_a_domain),
        .reset_n            (reset_n),
        .cmd_valid_i        (cmd_valid_i),
        .cmd_dout_i         (cmd_dout_i),
        .cmd_rd_en_o        (cmd_rd_en_o),
        .rsp_full_i         (rsp_full_i),
        .rsp_wr_en_o        (rsp_wr_en_o),
        .rsp_din_o          (rsp_din_o),
        .start_ready_i      (start_ready),
        .start_ready_rise_i (start_ready_rise),
        .loader_full_i      (loader_full),
        .load_o             (load),
        .payload_o          (load_payload),
        .ack_o              (ack),
        .gap_load_o         (gap_load),
        .gap_o              (gap_value)
    );

    stream_burst_gate u_burst_gate (
        .clk_a_domain (clk_a_domain),
        .reset_n      (reset_n),
        .gap_load_i   (gap_load),
        .gap_i        (gap_value),
        .data_valid_i (data_valid_i),
        .data_dout_i  (data_dout_i),
        .data_rd_en_o (data_rd_en_o),
        .beat_o       (gate_beat)
    );

endmodule

// File: testbench/a_domain_chk.sv
// bound into a_domain_top, pause check assumes a gap of 4 and a data FIFO that never runs dry
module a_domain_chk (
    input logic                       clk_a_domain,
    input logic                       reset_n,
    input logic                       rsp_full_i,
    input logic                       rsp_wr_en_i,
    input a_domain_pkg::cmd_word_t    rsp_din_i,
    input logic                       loader_full_i,
    input logic                       data_rd_en_i,
    input a_domain_pkg::stream_word_t data_dout_i,
    input a_domain_pkg::stream_beat_t asic_stream_i
);

    // idle cycles between bursts for the gap the testbench programs
    localparam int unsigned pause_cycles = 4;

    int unsigned fail_cnt = 0;
    int unsigned run_cnt;
    int unsigned last_run;
    int unsigned idle_cnt;

    // length of the current pop run and of the idle stretch before it
    always_ff @(posedge clk_a_domain) begin
        if (!reset_n) begin
            run_cnt  <= 0;
            last_run <= 0;
            idle_cnt <= 0;
        end else begin
            run_cnt  <= data_rd_en_i ? run_cnt + 1 : 0;
            idle_cnt <= data_rd_en_i ? 0 : idle_cnt + 1;
            if (!data_rd_en_i && run_cnt != 0) begin
                last_run <= run_cnt;
            end
        end
    end

    ack_after_full: assert property (@(posedge clk_a_domain) disable iff (!reset_n)
        $rose(loader_full_i) && !rsp_full_i |-> rsp_wr_en_i && rsp_din_i == 32'd2)
        else begin fail_cnt++; $error("no ack after the loader filled"); end

    no_write_when_full: assert property (@(posedge clk_a_domain) disable iff (!reset_n)
        rsp_full_i |-> !rsp_wr_en_i)
        else begin fail_cnt++; $error("response written into a full FIFO"); end

    beat_follows_pop: assert property (@(posedge clk_a_domain) disable iff (!reset_n)
        data_rd_en_i |=> asic_stream_i.valid && asic_stream_i.word == $past(data_dout_i))
        else begin fail_cnt++; $error("stream beat does not match the popped word"); end

    no_beat_without_pop: assert property (@(posedge clk_a_domain) disable iff (!reset_n)
        !data_rd_en_i |=> !asic_stream_i.valid)
        else begin fail_cnt++; $error("stream beat without a pop"); end

    burst_limit: assert property (@(posedge clk_a_domain) disable iff (!reset_n)
        data_rd_en_i |-> run_cnt < a_domain_pkg::burst_len)
        else begin fail_cnt++; $error("more than seven pops in a row"); end

    pause_length: assert property (@(posedge clk_a_domain) disable iff (!reset_n)
        data_rd_en_i && run_cnt == 0 && last_run == a_domain_pkg::burst_len
        |-> idle_cnt == pause_cycles)
        else begin fail_cnt++; $error("pause length differs from the gap"); end

endmodule

bind a_domain_top a_domain_chk u_chk (
    .clk_a_domain  (clk_a_domain),
    .reset_n       (reset_n),
    .rsp_full_i    (rsp_full_i),
    .rsp_wr_en_i   (rsp_wr_en_o),
    .rsp_din_i     (rsp_din_o),
    .loader_full_i (loader_full),
    .data_rd_en_i  (data_rd_en_o),
    .data_dout_i   (data_dout_i),
    .asic_stream_i (asic_stream_o)
);

// File: testbench/a_domain_tb.sv
// FIFO models are sampled on the falling edge and updated 2 units after the rising edge
module a_domain_tb;

    // limit well above the roughly 250 cycles of the run
    localparam int timeout_cycles = 3000;
    localparam int burst_words    = 28;

    logic                       clk_a_domain;
    logic                       reset_n;
    logic                       cmd_valid_i;
    a_domain_pkg::cmd_word_t    cmd_dout_i;
    logic                       cmd_rd_en_o;
    logic                       data_valid_i;
    a_domain_pkg::stream_word_t data_dout_i;
    logic                       data_rd_en_o;
    logic                       rsp_full_i;
    logic                       rsp_wr_en_o;
    a_domain_pkg::cmd_word_t    rsp_din_o;
    logic                       asic_start_ready_i;
    logic                       asic_reset_n_o;
    a_domain_pkg::stream_beat_t asic_stream_o;
    a_domain_pkg::asic_config_t asic_config_o;

    a_domain_pkg::cmd_word_t    cmd_q[$];
    a_domain_pkg::cmd_word_t    rsp_q[$];
    a_domain_pkg::stream_word_t data_q[$];
    a_domain_pkg::stream_word_t stream_q[$];
    a_domain_pkg::stream_word_t exp_q[$];
    a_domain_pkg::payload_t     pl[a_domain_pkg::config_words];
    logic                       cmd_pop = 1'b0;
    logic                       data_pop = 1'b0;
    logic [31:0]                lfsr_state = 32'h4611e98e;
    logic [65:0]                bits;
    int                         cycle_cnt = 0;
    int                         notice_cycle = 0;
    int                         rise_cycle;

    a_domain_top dut_i (.*);

    initial begin
        clk_a_domain = 1'b0;
        forever #20 clk_a_domain = ~clk_a_domain;
    end

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [65:0] exp, input logic [65:0] act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            report_fail("value check failed");
        end
    endtask

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [65:0] take_bits(input int n);
        logic [65:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[64:0], lfsr_state[31]};
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clk_a_domain);
        #2;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic wait_rsp(input int n);
        while (rsp_q.size() < n) next_cycle();
    endtask

    task automatic send_cmd(input a_domain_pkg::opcode_t op, input a_domain_pkg::payload_t pay);
        cmd_q.push_back({pay, op});
    endtask

    always @(posedge clk_a_domain) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) report_fail("timeout, the test did not finish in time");
        if (dut_i.u_chk.fail_cnt != 0) report_fail("a bound assertion failed");
    end

    always @(negedge clk_a_domain) begin
        cmd_pop  = cmd_rd_en_o;
        data_pop = data_rd_en_o;
        if (rsp_wr_en_o) begin
            rsp_q.push_back(rsp_din_o);
            // the FIFO takes the word on the next rising edge
            if (rsp_din_o[14:0] == a_domain_pkg::op_ready_notice) notice_cycle = cycle_cnt + 1;
        end
        if (asic_stream_o.valid) stream_q.push_back(asic_stream_o.word);
    end

    // FIFO model outputs
    always @(posedge clk_a_domain) begin
        #2;
        if (cmd_pop) cmd_q.delete(0);
        if (data_pop) data_q.delete(0);
        cmd_valid_i  = cmd_q.size() > 0;
        cmd_dout_i   = (cmd_q.size() > 0) ? cmd_q[0] : '0;
        data_valid_i = data_q.size() > 0;
        data_dout_i  = (data_q.size() > 0) ? data_q[0] : '0;
    end

    initial begin
        reset_n = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_dout_i = '0;
        data_valid_i = 1'b0;
        data_dout_i = '0;
        rsp_full_i = 1'b0;
        asic_start_ready_i = 1'b0;
        wait_cycles(3);
        check_eq("asic reset low", 0, 66'(asic_reset_n_o));
        reset_n = 1'b1;

        // configuration load and ack
        for (int i = 0; i < a_domain_pkg::config_words; i++) begin
            bits = take_bits(17);
            pl[i] = bits[16:0];
            send_cmd(a_domain_pkg::op_config, pl[i]);
        end
        wait_rsp(1);
        wait_cycles(4);
        check_eq("asic reset high", 1, 66'(asic_reset_n_o));
        check_eq("config ack count", 1, 66'(rsp_q.size()));
        check_eq("config ack", 66'(32'd2), 66'(rsp_q[0]));
        rsp_q.delete();
        check_eq("asic_mode", 66'(pl[0][1:0]), 66'(asic_config_o.asic_mode));
        check_eq("training_epochs", 66'(pl[1][15:0]), 66'(asic_config_o.training_epochs));
        check_eq("inference_epochs", 66'(pl[2][15:0]), 66'(asic_config_o.inference_epochs));
        check_eq("dataset", 66'(pl[3][1:0]), 66'(asic_config_o.dataset));
        check_eq("timesteps", 66'(pl[4][15:0]), 66'(asic_config_o.timesteps));
        check_eq("input_size_layer1", 66'(pl[5][15:0]),
                 66'(asic_config_o.input_size_layer1));
        check_eq("long_stream_mode", 66'(pl[6][0]), 66'(asic_config_o.long_stream_mode));
        check_eq("binary_classifier_mode", 66'(pl[7][0]),
                 66'(asic_config_o.binary_classifier_mode));
        check_eq("loser_encourage_mode", 66'(pl[8][0]),
                 66'(asic_config_o.loser_encourage_mode));
        for (int i = 0; i < a_domain_pkg::cut_count; i++) begin
            check_eq("layer1_cut", 66'(pl[9 + i]), {49'd0, asic_config_o.layer1_cut[i]});
            check_eq("layer2_cut", 66'(pl[24 + i][15:0]), {50'd0, asic_config_o.layer2_cut[i]});
        end

        // status with start_ready high and then low
        asic_start_ready_i = 1'b1;
        wait_cycles(3);
        send_cmd(a_domain_pkg::op_status, '0);
        wait_rsp(1);
        check_eq("status high", 66'(32'h0000_8007), 66'(rsp_q.pop_front()));
        asic_start_ready_i = 1'b0;
        wait_cycles(3);
        send_cmd(a_domain_pkg::op_status, '0);
        wait_rsp(1);
        check_eq("status low", 66'(32'h0000_0007), 66'(rsp_q.pop_front()));

        // start is held until start_ready and the notice follows the next rise
        send_cmd(a_domain_pkg::op_start, '0);
        wait_cycles(6);
        check_eq("start held", 1, 66'(cmd_q.size()));
        check_eq("start no response", 0, 66'(rsp_q.size()));
        asic_start_ready_i = 1'b1;
        wait_rsp(1);
        check_eq("start", 66'(32'h0000_0008), 66'(rsp_q.pop_front()));
        wait_cycles(4);
        asic_start_ready_i = 1'b0;
        wait_cycles(4);
        check_eq("no early notice", 0, 66'(rsp_q.size()));
        asic_start_ready_i = 1'b1;
        rise_cycle = cycle_cnt;
        wait_rsp(1);
        wait_cycles(4);
        check_eq("notice count", 1, 66'(rsp_q.size()));
        check_eq("notice", 66'(32'h0000_8009), 66'(rsp_q.pop_front()));
        check_eq("notice delay", 2, 66'(notice_cycle - rise_cycle));

        // bursts of seven with a gap of 4
        for (int i = 0; i < burst_words; i++) begin
            bits = take_bits(66);
            data_q.push_back(bits);
            exp_q.push_back(bits);
        end
        send_cmd(a_domain_pkg::op_stream_gap, 17'd4);
        wait_rsp(1);
        check_eq("gap echo", 66'({17'd4, a_domain_pkg::op_stream_gap}),
                 66'(rsp_q.pop_front()));
        while (stream_q.size() < burst_words) next_cycle();
        wait_cycles(6);
        check_eq("stream count", 66'(burst_words), 66'(stream_q.size()));
        for (int i = 0; i < burst_words; i++) begin
            check_eq("stream word", exp_q[i], stream_q[i]);
        end

        // back-pressure holds a status command
        rsp_full_i = 1'b1;
        send_cmd(a_domain_pkg::op_status, '0);
        wait_cycles(6);
        check_eq("status held", 1, 66'(cmd_q.size()));
        check_eq("no write while full", 0, 66'(rsp_q.size()));
        rsp_full_i = 1'b0;
        wait_rsp(1);
        check_eq("status after release", 66'(32'h0000_8007), 66'(rsp_q.pop_front()));
        wait_cycles(3);

        if (dut_i.u_chk.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_fail("a bound assertion failed");
        end
    end

endmodule

// File: vlog.f
logic/a_domain_pkg.sv
logic/asic_io_sync.sv
logic/config_loader.sv
logic/command_decoder.sv
logic/stream_burst_gate.sv
logic/a_domain_top.sv
testbench/a_domain_chk.sv
testbench/a_domain_tb.sv

// File: run.sh
#!/bin/sh
# build and run the a_domain testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module a_domain_tb -o a_domain_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/a_domain_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
